// File: Makefile
TOP = tb_decode_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: rtl/alu_op_decode.sv
`timescale 1ns/1ns
`default_nettype none

module alu_op_decode
  import rv_decode_pkg::*;
(
  input  opclass_e opclass,
  input  funct3_t  funct3,
  input  funct7_t  funct7,
  output alu_op_e  alu_op
);

  localparam funct7_t F7_BASE   = 7'b0000000;
  localparam funct7_t F7_ALT    = 7'b0100000;
  localparam funct7_t F7_MULDIV = 7'b0000001;

  always_comb begin
    alu_op = alu_none;
    case (opclass)
      // address and link arithmetic
      cls_load, cls_store, cls_jal, cls_auipc, cls_lui: alu_op = alu_add;
      cls_jalr: if (funct3 == 3'd0) alu_op = alu_add;

      // branch compares
      cls_branch: begin
        case (funct3)
          3'd0:    alu_op = alu_beq;
          3'd1:    alu_op = alu_bne;
          3'd4:    alu_op = alu_blt;
          3'd5:    alu_op = alu_bge;
          3'd6:    alu_op = alu_bltu;
          3'd7:    alu_op = alu_bgeu;
          default: alu_op = alu_none;
        endcase
      end

      // rv64 shamt is 6 bits, so funct7 bit 0 belongs to it
      cls_op_imm: begin
        case (funct3)
          3'd0: alu_op = alu_add;
          3'd1: if (funct7[6:1] == 6'b000000) alu_op = alu_sll;
          3'd2: alu_op = alu_slt;
          3'd3: alu_op = alu_sltu;
          3'd4: alu_op = alu_xor;
          3'd5: begin
            if (funct7[6:1] == 6'b000000) alu_op = alu_srl;
            else if (funct7[6:1] == 6'b010000) alu_op = alu_sra;
          end
          3'd6: alu_op = alu_or;
          3'd7: alu_op = alu_and;
          default: alu_op = alu_none;
        endcase
      end

      cls_op: begin
        if (funct7 == F7_MULDIV) begin
          // M table in funct3 order
          case (funct3)
            3'd0: alu_op = alu_mul;
            3'd1: alu_op = alu_mulh;
            3'd2: alu_op = alu_mulhsu;
            3'd3: alu_op = alu_mulhu;
            3'd4: alu_op = alu_div;
            3'd5: alu_op = alu_divu;
            3'd6: alu_op = alu_rem;
            3'd7: alu_op = alu_remu;
            default: alu_op = alu_none;
          endcase
        end else if (funct7 == F7_BASE) begin
          case (funct3)
            3'd0: alu_op = alu_add;
            3'd1: alu_op = alu_sll;
            3'd2: alu_op = alu_slt;
            3'd3: alu_op = alu_sltu;
            3'd4: alu_op = alu_xor;
            3'd5: alu_op = alu_srl;
            3'd6: alu_op = alu_or;
            3'd7: alu_op = alu_and;
            default: alu_op = alu_none;
          endcase
        end else if (funct7 == F7_ALT) begin
          if (funct3 == 3'd0) alu_op = alu_sub;
          else if (funct3 == 3'd5) alu_op = alu_sra;
        end
      end

      // word forms, add/sub share the 64-bit codes
      cls_op_32: begin
        case ({funct7, funct3})
          {F7_BASE, 3'd0}:   alu_op = alu_add;
          {F7_ALT, 3'd0}:    alu_op = alu_sub;
          {F7_BASE, 3'd1}:   alu_op = alu_sllw;
          {F7_BASE, 3'd5}:   alu_op = alu_srlw;
          {F7_ALT, 3'd5}:    alu_op = alu_sraw;
          {F7_MULDIV, 3'd0}: alu_op = alu_mulw;
          {F7_MULDIV, 3'd4}: alu_op = alu_divw;
          {F7_MULDIV, 3'd5}: alu_op = alu_divuw;
          {F7_MULDIV, 3'd6}: alu_op = alu_remw;
          {F7_MULDIV, 3'd7}: alu_op = alu_remuw;
          default:           alu_op = alu_none;
        endcase
      end

      // 5-bit shamt, full funct7 must match
      cls_op_imm_32: begin
        case (funct3)
          3'd0: alu_op = alu_add;
          3'd1: if (funct7 == F7_BASE) alu_op = alu_sllw;
          3'd5: begin
            if (funct7 == F7_BASE) alu_op = alu_srlw;
            else if (funct7 == F7_ALT) alu_op = alu_sraw;
          end
          default: alu_op = alu_none;
        endcase
      end

      default: alu_op = alu_none;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/ctrl_op_decode.sv
`timescale 1ns/1ns
`default_nettype none

module ctrl_op_decode
  import rv_decode_pkg::*;
(
  input  opclass_e    opclass,
  input  funct3_t     funct3,
  input  logic [11:0] sys_imm,
  output mem_op_e     mem_op,
  output exc_op_e     exc_op,
  output pc_op_e      pc_op
);

  logic is_ebreak;

  // ecall has imm 0, ebreak imm 1
  assign is_ebreak = (opclass == cls_system) && (funct3 == 3'd0) && (sys_imm == 12'd1);

  // access width and sign extension
  always_comb begin
    mem_op = mem_none;
    if (opclass == cls_load) begin
      case (funct3)
        3'd0:    mem_op = mem_lb;
        3'd1:    mem_op = mem_lh;
        3'd2:    mem_op = mem_lw;
        3'd3:    mem_op = mem_ld;
        3'd4:    mem_op = mem_lbu;
        3'd5:    mem_op = mem_lhu;
        3'd6:    mem_op = mem_lwu;
        default: mem_op = mem_none;
      endcase
    end else if (opclass == cls_store) begin
      case (funct3)
        3'd0:    mem_op = mem_sb;
        3'd1:    mem_op = mem_sh;
        3'd2:    mem_op = mem_sw;
        3'd3:    mem_op = mem_sd;
        default: mem_op = mem_none;
      endcase
    end
  end

  always_comb begin
    case (opclass)
      cls_auipc:     exc_op = exc_auipc;
      cls_lui:       exc_op = exc_lui;
      cls_jal:       exc_op = exc_jal;
      cls_jalr:      exc_op = exc_jalr;
      cls_load:      exc_op = exc_load;
      cls_store:     exc_op = exc_store;
      cls_branch:    exc_op = exc_branch;
      cls_op_imm:    exc_op = exc_opimm;
      cls_op_imm_32: exc_op = exc_opimm32;
      // the port shares its name with the enum member
      cls_op:        exc_op = rv_decode_pkg::exc_op;
      cls_op_32:     exc_op = exc_op32;
      // only ebreak survives from the system space
      cls_system:    exc_op = is_ebreak ? exc_ebreak : exc_none;
      default:       exc_op = exc_none;
    endcase
  end

  // priority chain, branch first
  always_comb begin
    if (opclass == cls_branch) begin
      pc_op = pc_branch;
    end else if (opclass == cls_jal) begin
      pc_op = pc_jal;
    end else if ((opclass == cls_jalr) && (funct3 == 3'd0)) begin
      pc_op = pc_jalr;
    end else begin
      pc_op = pc_inc4;
    end
  end

  always_comb begin
    assert final ((mem_op == mem_none) || (opclass inside {cls_load, cls_store}))
      else $error("ctrl_op_decode: %s issued for class %s", mem_op.name(), opclass.name());
  end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage
  import rv_decode_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     inst_valid,
  input  inst_t    inst,
  output logic     dec_valid,
  output reg_idx_t rs1_idx,
  output reg_idx_t rs2_idx,
  output reg_idx_t rd_idx,
  output imm_t     imm,
  output alu_op_e  alu_op,
  output mem_op_e  mem_op,
  output exc_op_e  exc_op,
  output pc_op_e   pc_op
);

  // raw instruction fields
  logic [6:0] opcode;
  funct3_t    funct3;
  funct7_t    funct7;
  reg_idx_t   rs1_field;
  reg_idx_t   rs2_field;
  reg_idx_t   rd_field;

  // decoded, not yet registered
  opclass_e opclass;
  fmt_e     fmt;
  reg_idx_t rs1_nxt;
  reg_idx_t rs2_nxt;
  reg_idx_t rd_nxt;
  imm_t     imm_nxt;
  alu_op_e  alu_op_nxt;
  mem_op_e  mem_op_nxt;
  exc_op_e  exc_op_nxt;
  pc_op_e   pc_op_nxt;

  assign opcode    = inst[6:0];
  assign rd_field  = inst[11:7];
  assign funct3    = inst[14:12];
  assign rs1_field = inst[19:15];
  assign rs2_field = inst[24:20];
  assign funct7    = inst[31:25];

  opcode_classify i_opcode_classify (
    .opcode  (opcode),
    .opclass (opclass),
    .fmt     (fmt)
  );

  operand_decode i_operand_decode (
    .fmt       (fmt),
    .inst      (inst),
    .rs1_field (rs1_field),
    .rs2_field (rs2_field),
    .rd_field  (rd_field),
    .rs1_idx   (rs1_nxt),
    .rs2_idx   (rs2_nxt),
    .rd_idx    (rd_nxt),
    .imm       (imm_nxt)
  );

  alu_op_decode i_alu_op_decode (
    .opclass (opclass),
    .funct3  (funct3),
    .funct7  (funct7),
    .alu_op  (alu_op_nxt)
  );

  ctrl_op_decode i_ctrl_op_decode (
    .opclass (opclass),
    .funct3  (funct3),
    .sys_imm (inst[31:20]),
    .mem_op  (mem_op_nxt),
    .exc_op  (exc_op_nxt),
    .pc_op   (pc_op_nxt)
  );

  // decode/execute pipeline register, fields hold while idle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
      rs1_idx   <= '0;
      rs2_idx   <= '0;
      rd_idx    <= '0;
      imm       <= '0;
      alu_op    <= alu_none;
      mem_op    <= mem_none;
      exc_op    <= exc_none;
      pc_op     <= pc_inc4;
    end else begin
      dec_valid <= inst_valid;
      if (inst_valid) begin
        rs1_idx <= rs1_nxt;
        rs2_idx <= rs2_nxt;
        rd_idx  <= rd_nxt;
        imm     <= imm_nxt;
        alu_op  <= alu_op_nxt;
        mem_op  <= mem_op_nxt;
        exc_op  <= exc_op_nxt;
        pc_op   <= pc_op_nxt;
      end
    end
  end

  a_dec_valid_known: assert property (
    @(posedge clk) disable iff (!arst_n) !$isunknown(dec_valid)
  ) else $error("decode_stage: dec_valid is unknown");

endmodule

`default_nettype wire

// File: rtl/opcode_classify.sv
`timescale 1ns/1ns
`default_nettype none

module opcode_classify
  import rv_decode_pkg::*;
(
  input  logic [6:0] opcode,
  output opclass_e   opclass,
  output fmt_e       fmt
);

  // full 7-bit match, anything unlisted is treated as no instruction
  always_comb begin
    case (opcode)
      opc_load:      opclass = cls_load;
      opc_store:     opclass = cls_store;
      opc_branch:    opclass = cls_branch;
      opc_jalr:      opclass = cls_jalr;
      opc_jal:       opclass = cls_jal;
      opc_op_imm:    opclass = cls_op_imm;
      opc_op:        opclass = cls_op;
      opc_auipc:     opclass = cls_auipc;
      opc_lui:       opclass = cls_lui;
      opc_op_imm_32: opclass = cls_op_imm_32;
      opc_op_32:     opclass = cls_op_32;
      opc_system:    opclass = cls_system;
      default:       opclass = cls_none;
    endcase
  end

  // operand layout per class
  always_comb begin
    case (opclass)
      cls_op, cls_op_32:                         fmt = fmt_r;
      cls_load, cls_op_imm, cls_op_imm_32, cls_jalr: fmt = fmt_i;
      cls_store:                                 fmt = fmt_s;
      cls_branch:                                fmt = fmt_b;
      cls_auipc, cls_lui:                        fmt = fmt_u;
      cls_jal:                                   fmt = fmt_j;
      // system carries no register operands here
      default:                                   fmt = fmt_none;
    endcase
  end

  // every real operand class must get a layout
  always_comb begin
    assert final ((fmt == fmt_none) == (opclass inside {cls_none, cls_system}))
      else $error("opcode_classify: class %s has format %s", opclass.name(), fmt.name());
  end

endmodule

`default_nettype wire

// File: rtl/operand_decode.sv
`timescale 1ns/1ns
`default_nettype none

module operand_decode
  import rv_decode_pkg::*;
(
  input  fmt_e     fmt,
  input  inst_t    inst,
  input  reg_idx_t rs1_field,
  input  reg_idx_t rs2_field,
  input  reg_idx_t rd_field,
  output reg_idx_t rs1_idx,
  output reg_idx_t rs2_idx,
  output reg_idx_t rd_idx,
  output imm_t     imm
);

  imm_t imm_i;
  imm_t imm_s;
  imm_t imm_b;
  imm_t imm_u;
  imm_t imm_j;

  logic use_rs1;
  logic use_rs2;
  logic use_rd;

  // all layouts sign-extend from bit 31
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (fmt)
      fmt_i:   imm = imm_i;
      fmt_s:   imm = imm_s;
      fmt_b:   imm = imm_b;
      fmt_u:   imm = imm_u;
      fmt_j:   imm = imm_j;
      default: imm = '0;
    endcase
  end

  // which register fields the format really carries
  assign use_rs1 = fmt inside {fmt_r, fmt_i, fmt_s, fmt_b};
  assign use_rs2 = fmt inside {fmt_r, fmt_s, fmt_b};
  assign use_rd  = fmt inside {fmt_r, fmt_i, fmt_u, fmt_j};

  assign rs1_idx = use_rs1 ? rs1_field : '0;
  assign rs2_idx = use_rs2 ? rs2_field : '0;
  assign rd_idx  = use_rd  ? rd_field  : '0;

  always_comb begin
    assert final (!(fmt inside {fmt_r, fmt_none}) || (imm == '0))
      else $error("operand_decode: immediate %h for format %s", imm, fmt.name());
  end

endmodule

`default_nettype wire

// File: rtl/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

  // instruction field widths
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [63:0] imm_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // major opcodes of the kept RV64IM classes
  typedef enum logic [6:0] {
    opc_load      = 7'b0000011,
    opc_op_imm    = 7'b0010011,
    opc_auipc     = 7'b0010111,
    opc_op_imm_32 = 7'b0011011,
    opc_store     = 7'b0100011,
    opc_op        = 7'b0110011,
    opc_lui       = 7'b0110111,
    opc_op_32     = 7'b0111011,
    opc_branch    = 7'b1100011,
    opc_jalr      = 7'b1100111,
    opc_jal       = 7'b1101111,
    opc_system    = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    cls_none, cls_load, cls_store, cls_branch, cls_jalr, cls_jal, cls_op_imm,
    cls_op, cls_auipc, cls_lui, cls_op_imm_32, cls_op_32, cls_system
  } opclass_e;

  typedef enum logic [2:0] {
    fmt_none, fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j
  } fmt_e;

  typedef enum logic [5:0] {
    alu_none = 6'd0,
    alu_add, alu_sub, alu_xor, alu_or, alu_and,
    // shifts, the w forms work on the low word
    alu_sll, alu_srl, alu_sra, alu_sllw, alu_srlw, alu_sraw,
    // set-less-than and branch compares
    alu_slt, alu_sltu, alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu,
    // M extension
    alu_mul, alu_mulh, alu_mulhsu, alu_mulhu, alu_mulw,
    alu_div, alu_divu, alu_rem, alu_remu, alu_divw, alu_divuw, alu_remw, alu_remuw
  } alu_op_e;

  typedef enum logic [3:0] {
    mem_none = 4'd0,
    mem_lb, mem_lh, mem_lw, mem_ld, mem_lbu, mem_lhu, mem_lwu,
    mem_sb, mem_sh, mem_sw, mem_sd
  } mem_op_e;

  typedef enum logic [3:0] {
    exc_none = 4'd0,
    exc_auipc, exc_lui, exc_jal, exc_jalr, exc_load, exc_store, exc_branch,
    exc_opimm, exc_opimm32, exc_op, exc_op32, exc_ebreak
  } exc_op_e;

  typedef enum logic [1:0] {
    pc_inc4 = 2'd0,
    pc_branch,
    pc_jal,
    pc_jalr
  } pc_op_e;

endpackage

`default_nettype wire

// File: sim.f
+incdir+verification
rtl/rv_decode_pkg.sv
rtl/opcode_classify.sv
rtl/operand_decode.sv
rtl/alu_op_decode.sv
rtl/ctrl_op_decode.sv
rtl/decode_stage.sv
verification/tb_decode_stage.sv

// File: verification/tb_decode_ref.svh
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// one decoded result, all zero is the reset set
typedef struct packed {
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  imm_t     imm;
  alu_op_e  alu;
  mem_op_e  mem;
  exc_op_e  exc;
  pc_op_e   pc;
} dec_fields_t;

// lookup tables indexed by funct3
localparam alu_op_e ref_branch_tab [8] = '{alu_beq, alu_bne, alu_none, alu_none,
                                           alu_blt, alu_bge, alu_bltu, alu_bgeu};
localparam alu_op_e ref_r_tab [8] = '{alu_add, alu_sll, alu_slt, alu_sltu,
                                      alu_xor, alu_srl, alu_or, alu_and};
localparam alu_op_e ref_m_tab [8] = '{alu_mul, alu_mulh, alu_mulhsu, alu_mulhu,
                                      alu_div, alu_divu, alu_rem, alu_remu};
localparam alu_op_e ref_mw_tab [8] = '{alu_mulw, alu_none, alu_none, alu_none,
                                       alu_divw, alu_divuw, alu_remw, alu_remuw};
localparam mem_op_e ref_load_tab [8] = '{mem_lb, mem_lh, mem_lw, mem_ld,
                                         mem_lbu, mem_lhu, mem_lwu, mem_none};
localparam mem_op_e ref_store_tab [8] = '{mem_sb, mem_sh, mem_sw, mem_sd,
                                          mem_none, mem_none, mem_none, mem_none};

function automatic fmt_e ref_format(logic [6:0] opc);
  case (opc)
    7'h33, 7'h3b:               return fmt_r;
    7'h03, 7'h13, 7'h1b, 7'h67: return fmt_i;
    7'h23:                      return fmt_s;
    7'h63:                      return fmt_b;
    7'h17, 7'h37:               return fmt_u;
    7'h6f:                      return fmt_j;
    default:                    return fmt_none;
  endcase
endfunction

// copy the top valid bit upwards
function automatic imm_t sign_extend(imm_t raw, int unsigned width);
  imm_t r;
  r = raw;
  for (int unsigned b = width; b < 64; b++) begin
    r[b] = raw[width-1];
  end
  return r;
endfunction

function automatic imm_t ref_imm(inst_t w, fmt_e f);
  case (f)
    fmt_i:   return sign_extend(imm_t'(w[31:20]), 12);
    fmt_s:   return sign_extend(imm_t'({w[31:25], w[11:7]}), 12);
    fmt_b:   return sign_extend(imm_t'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
    fmt_u:   return sign_extend(imm_t'({w[31:12], 12'h000}), 32);
    fmt_j:   return sign_extend(imm_t'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
    default: return '0;
  endcase
endfunction

// sllw, srlw, sraw need the exact funct7
function automatic alu_op_e ref_word_shift(funct3_t f3, funct7_t f7);
  if (f3 == 3'd1 && f7 == 7'h00) return alu_sllw;
  if (f3 == 3'd5 && f7 == 7'h00) return alu_srlw;
  if (f3 == 3'd5 && f7 == 7'h20) return alu_sraw;
  return alu_none;
endfunction

function automatic alu_op_e ref_alu(inst_t w);
  funct3_t f3;
  funct7_t f7;
  f3 = w[14:12];
  f7 = w[31:25];
  case (w[6:0])
    7'h03, 7'h23, 7'h6f, 7'h17, 7'h37: return alu_add;
    7'h67: return (f3 == 3'd0) ? alu_add : alu_none;
    7'h63: return ref_branch_tab[f3];
    7'h13: begin
      if (f3 != 3'd1 && f3 != 3'd5) return ref_r_tab[f3];
      // bit 0 of funct7 is shamt[5]
      if (f7[6:1] == 6'b000000) return ref_r_tab[f3];
      if (f3 == 3'd5 && f7[6:1] == 6'b010000) return alu_sra;
      return alu_none;
    end
    7'h33: begin
      if (f7 == 7'h00) return ref_r_tab[f3];
      if (f7 == 7'h01) return ref_m_tab[f3];
      if (f7 == 7'h20 && f3 == 3'd0) return alu_sub;
      if (f7 == 7'h20 && f3 == 3'd5) return alu_sra;
      return alu_none;
    end
    7'h3b: begin
      if (f7 == 7'h01) return ref_mw_tab[f3];
      if (f3 == 3'd0 && f7 == 7'h00) return alu_add;
      if (f3 == 3'd0 && f7 == 7'h20) return alu_sub;
      return ref_word_shift(f3, f7);
    end
    7'h1b: return (f3 == 3'd0) ? alu_add : ref_word_shift(f3, f7);
    default: return alu_none;
  endcase
endfunction

function automatic exc_op_e ref_exc(inst_t w);
  case (w[6:0])
    7'h17:   return exc_auipc;
    7'h37:   return exc_lui;
    7'h6f:   return exc_jal;
    7'h67:   return exc_jalr;
    7'h03:   return exc_load;
    7'h23:   return exc_store;
    7'h63:   return exc_branch;
    7'h13:   return exc_opimm;
    7'h1b:   return exc_opimm32;
    // the testbench has a signal of the same name
    7'h33:   return rv_decode_pkg::exc_op;
    7'h3b:   return exc_op32;
    7'h73:   return (w[14:12] == 3'd0 && w[31:20] == 12'd1) ? exc_ebreak : exc_none;
    default: return exc_none;
  endcase
endfunction

function automatic dec_fields_t decode_ref(inst_t w);
  dec_fields_t d;
  fmt_e        f;
  f     = ref_format(w[6:0]);
  d.rs1 = (f inside {fmt_r, fmt_i, fmt_s, fmt_b}) ? w[19:15] : 5'd0;
  d.rs2 = (f inside {fmt_r, fmt_s, fmt_b}) ? w[24:20] : 5'd0;
  d.rd  = (f inside {fmt_r, fmt_i, fmt_u, fmt_j}) ? w[11:7] : 5'd0;
  d.imm = ref_imm(w, f);
  d.alu = ref_alu(w);
  case (w[6:0])
    7'h03:   d.mem = ref_load_tab[w[14:12]];
    7'h23:   d.mem = ref_store_tab[w[14:12]];
    default: d.mem = mem_none;
  endcase
  d.exc = ref_exc(w);
  if (w[6:0] == 7'h63) d.pc = pc_branch;
  else if (w[6:0] == 7'h6f) d.pc = pc_jal;
  else if (w[6:0] == 7'h67 && w[14:12] == 3'd0) d.pc = pc_jalr;
  else d.pc = pc_inc4;
  return d;
endfunction

`endif

// File: verification/tb_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decode_stage
  import rv_decode_pkg::*;
;

  logic     clk;
  logic     arst_n;
  logic     inst_valid;
  inst_t    inst;
  logic     dec_valid;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  reg_idx_t rd_idx;
  imm_t     imm;
  alu_op_e  alu_op;
  mem_op_e  mem_op;
  exc_op_e  exc_op;
  pc_op_e   pc_op;

  `include "tb_decode_ref.svh"

  localparam logic [6:0] kept_opcodes [12] = '{7'h03, 7'h23, 7'h63, 7'h67, 7'h6f, 7'h13,
                                               7'h33, 7'h17, 7'h37, 7'h1b, 7'h3b, 7'h73};
  // opcodes whose funct3/funct7 are swept, funct7 picks include shamt[5] set
  localparam logic [6:0] swept_opcodes [8] = '{7'h33, 7'h3b, 7'h13, 7'h1b,
                                               7'h63, 7'h67, 7'h03, 7'h23};
  localparam funct7_t funct7_picks [6] = '{7'h00, 7'h20, 7'h01, 7'h21, 7'h02, 7'h40};
  localparam logic [6:0] unknown_opcodes [5] = '{7'h0f, 7'h2f, 7'h07, 7'h53, 7'h7f};

  dec_fields_t exp_q[$];
  dec_fields_t held = '0;
  logic        valid_d = 1'b0;
  int unsigned n_issued = 0;
  int unsigned n_checked = 0;

  decode_stage i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .dec_valid  (dec_valid),
    .rs1_idx    (rs1_idx),
    .rs2_idx    (rs2_idx),
    .rd_idx     (rd_idx),
    .imm        (imm),
    .alu_op     (alu_op),
    .mem_op     (mem_op),
    .exc_op     (exc_op),
    .pc_op      (pc_op)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_fail(string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_idx(string what, reg_idx_t got, reg_idx_t exp);
    if (got !== exp)
      report_fail($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_imm(imm_t got, imm_t exp);
    if (got !== exp)
      report_fail($sformatf("Error at %0t ns: imm is %h, expected %h", $time, got, exp));
  endtask

  task automatic check_alu(alu_op_e got, alu_op_e exp);
    if (got !== exp)
      report_fail($sformatf("Error at %0t ns: alu_op is %s (%0d), expected %s",
                            $time, got.name(), got, exp.name()));
  endtask

  task automatic check_mem(mem_op_e got, mem_op_e exp);
    if (got !== exp)
      report_fail($sformatf("Error at %0t ns: mem_op is %s (%0d), expected %s",
                            $time, got.name(), got, exp.name()));
  endtask

  task automatic check_exc(exc_op_e got, exc_op_e exp);
    if (got !== exp)
      report_fail($sformatf("Error at %0t ns: exc_op is %s (%0d), expected %s",
                            $time, got.name(), got, exp.name()));
  endtask

  task automatic check_pc(pc_op_e got, pc_op_e exp);
    if (got !== exp)
      report_fail($sformatf("Error at %0t ns: pc_op is %s (%0d), expected %s",
                            $time, got.name(), got, exp.name()));
  endtask

  task automatic check_fields(dec_fields_t e);
    check_idx("rs1_idx", rs1_idx, e.rs1);
    check_idx("rs2_idx", rs2_idx, e.rs2);
    check_idx("rd_idx", rd_idx, e.rd);
    check_imm(imm, e.imm);
    check_alu(alu_op, e.alu);
    check_mem(mem_op, e.mem);
    check_exc(exc_op, e.exc);
    check_pc(pc_op, e.pc);
  endtask

  // outputs seen here were registered at the previous rising edge
  always @(posedge clk) begin
    if (!arst_n) begin
      valid_d = 1'b0;
    end else begin
      if (dec_valid !== valid_d)
        report_fail($sformatf("Error at %0t ns: dec_valid is %b, expected %b",
                              $time, dec_valid, valid_d));
      if (dec_valid) begin
        if (exp_q.size() == 0)
          report_fail("dec_valid was high with no instruction outstanding");
        held = exp_q.pop_front();
        n_checked++;
      end
      // idle cycles must show the last result unchanged
      check_fields(held);
      valid_d = inst_valid;
    end
  end

  task automatic issue(inst_t w);
    @(negedge clk);
    inst_valid = 1'b1;
    inst       = w;
    exp_q.push_back(decode_ref(w));
    n_issued++;
  endtask

  task automatic insert_gap();
    @(negedge clk);
    inst_valid = 1'b0;
    inst       = $urandom();
  endtask

  function automatic inst_t with_opcode(logic [6:0] opc);
    inst_t w;
    w      = $urandom();
    w[6:0] = opc;
    return w;
  endfunction

  initial begin
    inst_t       w;
    int unsigned drain;
    arst_n     = 1'b0;
    inst_valid = 1'b1;
    inst       = 32'h00a00093;
    void'($urandom(32'h920eb93a));

    // valid input during reset must not leak through
    repeat (10) @(posedge clk);
    @(negedge clk);
    if (dec_valid !== 1'b0)
      report_fail($sformatf("Error at %0t ns: dec_valid is %b in reset", $time, dec_valid));
    check_fields('0);
    arst_n     = 1'b1;
    inst_valid = 1'b0;
    insert_gap();

    // every kept class, bit 31 clear and set
    foreach (kept_opcodes[k]) begin
      for (int s = 0; s < 2; s++) begin
        w     = with_opcode(kept_opcodes[k]);
        w[31] = s[0];
        issue(w);
      end
    end
    insert_gap();

    // funct3 x funct7 sweep, covers alu, load and store tables
    foreach (swept_opcodes[k]) begin
      foreach (funct7_picks[j]) begin
        for (int f3 = 0; f3 < 8; f3++) begin
          w        = with_opcode(swept_opcodes[k]);
          w[14:12] = funct3_t'(f3);
          w[31:25] = funct7_picks[j];
          issue(w);
        end
      end
    end
    insert_gap();

    // ebreak, ecall, csrrw, ebreak pattern with funct3 set
    issue(32'h00100073);
    issue(32'h00000073);
    issue(32'h34029073);
    issue(32'h00101073);
    for (int n = 0; n < 8; n++) issue(with_opcode(7'h73));
    foreach (unknown_opcodes[k]) issue(with_opcode(unknown_opcodes[k]));
    insert_gap();

    // random words with random idle cycles
    for (int n = 0; n < 2000; n++) begin
      if ($urandom_range(3) == 0) insert_gap();
      w = $urandom();
      if ($urandom_range(1) == 1) w[6:0] = kept_opcodes[$urandom_range(11)];
      issue(w);
    end
    insert_gap();

    drain = 0;
    while (exp_q.size() != 0 && drain < 20) begin
      @(negedge clk);
      drain++;
    end
    @(negedge clk);

    if (exp_q.size() == 0 && n_checked == n_issued) begin
      $display("checked %0d decoded instructions", n_checked);
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_fail($sformatf("timeout: %0d results never came out of the decode stage",
                            exp_q.size()));
    end
  end

endmodule

`default_nettype wire
